// ==== bench/routerArbTests.svh ====
  // ======================================================================
  // directed tests
  // ======================================================================

  task automatic resetTest();
    // outputs stay clear through reset.
    repeat (resetCycles)
    begin
      @(negedge clk);
      checkFlit("outFlit", outFlit, '0);
      checkGrant("outGrant", outGrant, '0);
    end
    rst = 1'b0;
    advance(2);
  endtask

  // north alone, four grant cycles then one idle.
  task automatic lonePortTest();
    sendHeader(1, 12'd3);
    runAndMeasure(1, lonePortCycles, 4);
    portIn[1] = '0;
    advance(drainCycles);
  endtask

  task automatic sharedGrantTest();
    sendHeader(0, 12'd2);
    sendHeader(2, 12'd5);
    runAndMeasure(0, sharedCycles, 3);
    runAndMeasure(2, sharedCycles, 6);
    portIn[0] = '0;
    portIn[2] = '0;
    advance(drainCycles);
  endtask

  task automatic rotationTest();
    sendHeader(1, 12'd1);
    sendHeader(3, 12'd2);
    sendHeader(4, 12'd0);
    // first grant reaches the output three edges later.
    runBodies(3);
    checkGrant("outGrant", outGrant, 5'b00010);
    runBodies(rotateCycles);
    portIn[1] = '0;
    portIn[3] = '0;
    portIn[4] = '0;
    advance(drainCycles);
  endtask

  // east lets go early, south takes over right away.
  task automatic earlyReleaseTest();
    sendHeader(2, 12'd10);
    sendHeader(4, 12'd1);
    runBodies(4);
    portIn[2] = '0;
    runBodies(3);
    checkGrant("outGrant", outGrant, 5'b10000);
    runBodies(releaseCycles);
    portIn[4] = '0;
    advance(drainCycles);
  endtask

  task automatic budgetReloadTest();
    sendHeader(1, 12'd2);
    runAndMeasure(1, reloadCycles, 3);
    portIn[1] = '0;
    advance(drainCycles);
    sendHeader(1, 12'd5);
    runAndMeasure(1, reloadCycles, 6);
    portIn[1] = '0;
    advance(drainCycles);
  endtask

// ==== bench/routerArbTb.sv ====
`timescale 1ns/1ns

module routerArbTb;

  import nocPkg::*;
  import arbPkg::*;

  localparam int clkPeriod = 8;
  localparam int resetCycles = 5;
  localparam int drainCycles = 4;
  localparam int lonePortCycles = 32;
  localparam int sharedCycles = 30;
  localparam int rotateCycles = 30;
  localparam int releaseCycles = 16;
  localparam int reloadCycles = 20;
  localparam int watchdogCycles = resetCycles + lonePortCycles + 2 * sharedCycles
    + rotateCycles + releaseCycles + 2 * reloadCycles + 8 * drainCycles + 64;

  localparam flitIdT bodyId = 3'd2;

  logic   clk;
  logic   rst;
  flitT   portIn [numPorts];
  flitT   outFlit;
  grantT  outGrant;

  // reference copy of the pipeline, the arbiter and the timers.
  flitT   mReg [numPorts];
  lengthT mBudget [numPorts];
  lengthT mCount [numPorts];
  int     mHolder;
  flitT   mOut;
  grantT  mOutGrant;

  int flitErrors;
  int grantErrors;
  int holdErrors;
  logic [31:0] lfsr;

  initial clk = 1'b0;
  always #(clkPeriod / 2) clk = ~clk;

  routerArbTop routerArbTop_inst (
    .clk      (clk),
    .rst      (rst),
    .portIn   (portIn),
    .outFlit  (outFlit),
    .outGrant (outGrant)
  );

  // ======================================================================
  // reference model
  // ======================================================================

  always @(posedge clk)
  begin : refModel
    int nextHolder;
    int cand;
    if (rst)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        mReg[p] = '0;
        mBudget[p] = '0;
        mCount[p] = '0;
      end
      mHolder = -1;
      mOut = '0;
      mOutGrant = '0;
    end
    else
    begin
      // output stage sees the grant before the state moves.
      if (mHolder >= 0)
      begin
        mOut = mReg[mHolder];
        mOutGrant = grantT'(5'b00001 << mHolder);
      end
      else
      begin
        mOut = '0;
        mOutGrant = '0;
      end
      nextHolder = -1;
      if (mHolder < 0)
      begin
        for (int k = 0; k < numPorts; k++)
        begin
          if (nextHolder < 0 && mReg[k].valid)
            nextHolder = k;
        end
      end
      else if (mReg[mHolder].valid && mCount[mHolder] != mBudget[mHolder])
      begin
        nextHolder = mHolder;
      end
      else
      begin
        // search the others in rotation after the holder.
        for (int k = 1; k < numPorts; k++)
        begin
          cand = (mHolder + k) % numPorts;
          if (nextHolder < 0 && mReg[cand].valid)
            nextHolder = cand;
        end
      end
      for (int p = 0; p < numPorts; p++)
      begin
        if (p == mHolder && nextHolder == mHolder)
          mCount[p] = mCount[p] + 1'b1;
        else
          mCount[p] = '0;
      end
      mHolder = nextHolder;
      for (int p = 0; p < numPorts; p++)
      begin
        if (portIn[p].valid && portIn[p].id == headerId)
          mBudget[p] = portIn[p].length;
        mReg[p] = portIn[p];
      end
    end
  end

  // ======================================================================
  // stimulus and compare helpers
  // ======================================================================

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per payload bit.
  task automatic randPayload(output payloadT d);
    for (int i = 0; i < $bits(payloadT); i++)
    begin
      lfsr = lfsrStep(lfsr);
      d[i] = lfsr[0];
    end
  endtask

  task automatic sendHeader(input int port, input lengthT len);
    payloadT d;
    randPayload(d);
    portIn[port] = '0;
    portIn[port].valid = 1'b1;
    portIn[port].id = headerId;
    portIn[port].length = len;
    portIn[port].data = d;
  endtask

  // active ports move on to body flits with fresh payloads.
  task automatic refreshBodies();
    payloadT d;
    for (int p = 0; p < numPorts; p++)
    begin
      if (portIn[p].valid)
      begin
        randPayload(d);
        portIn[p] = '0;
        portIn[p].valid = 1'b1;
        portIn[p].id = bodyId;
        portIn[p].data = d;
      end
    end
  endtask

  task automatic checkFlit(input string name, input flitT got, input flitT exp);
    if (exp.valid)
    begin
      if (got !== exp)
      begin
        $display("ERROR %s: got %h expected %h", name, got, exp);
        flitErrors++;
      end
    end
    else if (got.valid !== 1'b0)
    begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      flitErrors++;
    end
  endtask

  task automatic checkGrant(input string name, input grantT got, input grantT exp);
    if (got !== exp)
    begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      grantErrors++;
    end
  endtask

  task automatic advance(input int n);
    repeat (n)
    begin
      @(negedge clk);
      checkFlit("outFlit", outFlit, mOut);
      checkGrant("outGrant", outGrant, mOutGrant);
    end
  endtask

  task automatic runBodies(input int cycles);
    repeat (cycles)
    begin
      advance(1);
      refreshBodies();
    end
  endtask

  // every complete grant run of the port must last expLen cycles.
  task automatic runAndMeasure(input int port, input int cycles, input int expLen);
    logic wasHigh;
    logic counting;
    int   len;
    wasHigh = 1'b1;
    counting = 1'b0;
    len = 0;
    repeat (cycles)
    begin
      runBodies(1);
      if (outGrant[port])
      begin
        if (!wasHigh)
        begin
          counting = 1'b1;
          len = 0;
        end
        len++;
      end
      else if (wasHigh && counting)
      begin
        if (len != expLen)
        begin
          $display("port %0d held the grant for %0d cycles instead of %0d", port, len, expLen);
          holdErrors++;
        end
        counting = 1'b0;
      end
      wasHigh = outGrant[port];
    end
  endtask

  `include "routerArbTests.svh"

  initial
  begin
    flitErrors = 0;
    grantErrors = 0;
    holdErrors = 0;
    lfsr = 32'h80c570c0;
    rst = 1'b1;
    for (int p = 0; p < numPorts; p++)
      portIn[p] = '0;
    resetTest();
    lonePortTest();
    sharedGrantTest();
    rotationTest();
    earlyReleaseTest();
    budgetReloadTest();
    $display("error counts: flit %0d, grant %0d, hold %0d", flitErrors, grantErrors,
      holdErrors);
    if (flitErrors + grantErrors + holdErrors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin
    #(watchdogCycles * clkPeriod);
    $display("watchdog expired after %0d cycles, tests did not complete", watchdogCycles);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== rtl/arbPkg.sv ====
package arbPkg;

  // local, north, east, west, south.
  localparam int numPorts = 5;

  // port index, L 0, N 1, E 2, W 3, S 4.
  typedef logic [2:0] portT;

  // one-hot grant, bit n is port n.
  typedef logic [numPorts-1:0] grantT;

  // ======================================================================
  // arbiter states
  // ======================================================================

  // one-hot, grant bits sit above the idle bit.
  typedef enum logic [5:0] {
    idle   = 6'b000001,
    grantL = 6'b000010,
    grantN = 6'b000100,
    grantE = 6'b001000,
    grantW = 6'b010000,
    grantS = 6'b100000
  } arbStateT;

endpackage

// ==== rtl/flitDecoder.sv ====
`timescale 1ns/1ns

module flitDecoder (
  input  logic           clk,
  input  logic           rst,
  input  nocPkg::flitT   inFlit,
  output nocPkg::flitT   regFlit,
  output logic           req,
  output nocPkg::lengthT budget
);

  import nocPkg::*;

  logic isHeader;

  assign isHeader = inFlit.valid && (inFlit.id == headerId);

  // one register stage per port.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      regFlit <= '0;
    end
    else
    begin
      regFlit <= inFlit;
    end
  end

  // budget follows the length of the latest header.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
    end
    else if (isHeader)
    begin
      budget <= inFlit.length;
    end
  end

  // request is the registered valid level.
  assign req = regFlit.valid;

endmodule

// ==== rtl/grantTimer.sv ====
`timescale 1ns/1ns

module grantTimer (
  input  logic           clk,
  input  logic           rst,
  input  logic           run,
  input  nocPkg::lengthT budget,
  output logic           timesUp
);

  import nocPkg::*;

  lengthT count;

  // counts cycles of held grant, clears otherwise.
  always_ff @(posedge clk)
  begin
    if (rst || !run)
    begin
      count <= '0;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  assign timesUp = (count == budget);

  // a running count must hit the budget before passing it.
  countInBudget: assert property (@(posedge clk) disable iff (rst)
    run |-> count <= budget);

endmodule

// ==== rtl/nocPkg.sv ====
package nocPkg;

  // ======================================================================
  // flit fields
  // ======================================================================

  // flit kind, idle 0, header 1, body 2, tail 3.
  typedef logic [2:0] flitIdT;

  // packet length, doubles as the grant budget in cycles.
  typedef logic [11:0] lengthT;

  typedef logic [15:0] payloadT;

  localparam flitIdT headerId = 3'd1;

  // ======================================================================
  // flit as seen on a port
  // ======================================================================

  // length is only meaningful on header flits.
  typedef struct packed {
    logic    valid;
    flitIdT  id;
    lengthT  length;
    payloadT data;
  } flitT;

endpackage

// ==== rtl/portArbiter.sv ====
`timescale 1ns/1ns

module portArbiter (
  input  logic           clk,
  input  logic           rst,
  input  arbPkg::grantT  req,
  input  nocPkg::lengthT budget [arbPkg::numPorts],
  output arbPkg::grantT  grant
);

  import arbPkg::*;

  arbStateT state;
  arbStateT nextState;
  portT     curPort;
  grantT    run;
  grantT    timesUp;

  function automatic arbStateT stateOf(input portT p);
    return arbStateT'(6'b000010 << p);
  endfunction

  // ======================================================================
  // per-port grant timers
  // ======================================================================

  for (genvar p = 0; p < numPorts; p++)
  begin : timerGen
    grantTimer timerInst (
      .clk     (clk),
      .rst     (rst),
      .run     (run[p]),
      .budget  (budget[p]),
      .timesUp (timesUp[p])
    );
  end

  // ======================================================================
  // state machine
  // ======================================================================

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= idle;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    case (state)
      grantL:  curPort = 3'd0;
      grantN:  curPort = 3'd1;
      grantE:  curPort = 3'd2;
      grantW:  curPort = 3'd3;
      grantS:  curPort = 3'd4;
      default: curPort = 3'd0;
    endcase
  end

  // lowest offset wins, so the loops run downwards.
  always_comb
  begin
    run = '0;
    nextState = idle;
    if (state == idle)
    begin
      for (int off = numPorts - 1; off >= 0; off--)
      begin
        if (req[off])
          nextState = stateOf(portT'(off));
      end
    end
    else if (req[curPort] && !timesUp[curPort])
    begin
      // hold while requesting and within budget.
      run[curPort] = 1'b1;
      nextState = state;
    end
    else
    begin
      // rotate, starting after the current holder.
      for (int off = numPorts - 1; off >= 1; off--)
      begin
        if (req[(curPort + off) % numPorts])
          nextState = stateOf(portT'((curPort + off) % numPorts));
      end
    end
  end

  assign grant = state[5:1];

  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant));

  // a new grant goes only to a port that asked for it.
  grantFromRequest: assert property (@(posedge clk) disable iff (rst)
    |(grant & ~$past(grant)) |-> |(grant & ~$past(grant) & $past(req)));

endmodule

// ==== rtl/routerArbTop.sv ====
`timescale 1ns/1ns

module routerArbTop (
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flitT  portIn [arbPkg::numPorts],
  output nocPkg::flitT  outFlit,
  output arbPkg::grantT outGrant
);

  import nocPkg::*;
  import arbPkg::*;

  flitT   regFlit [numPorts];
  lengthT budget [numPorts];
  grantT  req;
  grantT  grant;

  // ======================================================================
  // decode, one stage per port
  // ======================================================================

  for (genvar p = 0; p < numPorts; p++)
  begin : decodeGen
    flitDecoder decoderInst (
      .clk     (clk),
      .rst     (rst),
      .inFlit  (portIn[p]),
      .regFlit (regFlit[p]),
      .req     (req[p]),
      .budget  (budget[p])
    );
  end

  portArbiter arbiterInst (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .budget (budget),
    .grant  (grant)
  );

  switchOutput outputInst (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .portFlit (regFlit),
    .outFlit  (outFlit),
    .outGrant (outGrant)
  );

endmodule

// ==== rtl/switchOutput.sv ====
`timescale 1ns/1ns

module switchOutput (
  input  logic          clk,
  input  logic          rst,
  input  arbPkg::grantT grant,
  input  nocPkg::flitT  portFlit [arbPkg::numPorts],
  output nocPkg::flitT  outFlit,
  output arbPkg::grantT outGrant
);

  import nocPkg::*;
  import arbPkg::*;

  flitT selFlit;

  // one-hot crossbar mux.
  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p])
        selFlit = selFlit | portFlit[p];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit.valid <= 1'b0;
      outGrant <= '0;
    end
    else
    begin
      outFlit.valid <= selFlit.valid && (grant != '0);
      outGrant <= grant;
    end
    outFlit.id <= selFlit.id;
    outFlit.length <= selFlit.length;
    outFlit.data <= selFlit.data;
  end

  // the or-mux only yields a clean flit from a single grant bit.
  validHasGrant: assert property (@(posedge clk) disable iff (rst)
    outFlit.valid |-> $onehot(outGrant));

endmodule

// ==== tb.f ====
+incdir+bench
rtl/nocPkg.sv
rtl/arbPkg.sv
rtl/flitDecoder.sv
rtl/grantTimer.sv
rtl/portArbiter.sv
rtl/switchOutput.sv
rtl/routerArbTop.sv
bench/routerArbTb.sv
